// ==== Makefile ====
# Verilator flow for the floating-point coprocessor
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_fpu
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
src/fpu_fmt_pkg.sv
src/fpu_ctrl_pkg.sv
src/fpu_bus_regs.sv
src/fpu_sequencer.sv
src/fpu_shift_add_mul.sv
src/fpu_restoring_div.sv
src/fpu_result_pack.sv
src/fpu_top.sv
test/fpu_checker.sv
test/tb_fpu.sv

// ==== src/fpu_bus_regs.sv ====
/*
  host register file. writes land on the edge where cs and wr are low.
  reads are combinational and return zero when not selected.
  a start write with an op other than mul or div is dropped.
  only the low nibble of the op byte is stored.
*/
`timescale 1ns/1ps

module fpu_bus_regs
  import fpu_fmt_pkg::*, fpu_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      arst,
  input  bus_req_t  bus,
  output bus_data_t rdata,
  output operands_t ops,
  input  fp32_t     result,
  input  logic      result_valid,
  output logic      start,
  output logic      is_div
);

  fpu_op_e op_q;
  logic    wr_en;
  logic    rd_en;
  logic    op_ok;

  assign wr_en = !bus.cs && !bus.wr;
  assign rd_en = !bus.cs && !bus.rd;
  assign op_ok = (op_q == op_mul) || (op_q == op_div);

  // ------------------------------
  // write side
  // ------------------------------
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      // both operands come up as 1.0
      ops.a  <= 32'h3f80_0000;
      ops.b  <= 32'h3f80_0000;
      op_q   <= op_mul;
      start  <= 1'b0;
      is_div <= 1'b0;
    end else begin
      start <= 1'b0;
      if (wr_en) begin
        case (bus.addr)
          reg_a0: ops.a[7:0]   <= bus.wdata;
          reg_a1: ops.a[15:8]  <= bus.wdata;
          reg_a2: ops.a[23:16] <= bus.wdata;
          reg_a3: ops.a[31:24] <= bus.wdata;
          reg_b0: ops.b[7:0]   <= bus.wdata;
          reg_b1: ops.b[15:8]  <= bus.wdata;
          reg_b2: ops.b[23:16] <= bus.wdata;
          reg_b3: ops.b[31:24] <= bus.wdata;
          reg_op: op_q <= fpu_op_e'(bus.wdata[3:0]);
          reg_start: begin
            start  <= op_ok;
            is_div <= (op_q == op_div);
          end
          default: ;
        endcase
      end
      // chained operations start from the last result
      if (result_valid) begin
        ops.a <= result;
      end
    end
  end

  // ------------------------------
  // readback mux
  // ------------------------------
  always_comb begin
    rdata = '0;
    if (rd_en) begin
      case (bus.addr)
        reg_a0:  rdata = ops.a[7:0];
        reg_a1:  rdata = ops.a[15:8];
        reg_a2:  rdata = ops.a[23:16];
        reg_a3:  rdata = ops.a[31:24];
        reg_b0:  rdata = ops.b[7:0];
        reg_b1:  rdata = ops.b[15:8];
        reg_b2:  rdata = ops.b[23:16];
        reg_b3:  rdata = ops.b[31:24];
        reg_op:  rdata = {4'b0000, op_q};
        reg_r0:  rdata = result[7:0];
        reg_r1:  rdata = result[15:8];
        reg_r2:  rdata = result[23:16];
        reg_r3:  rdata = result[31:24];
        default: rdata = '0;
      endcase
    end
  end

endmodule

// ==== src/fpu_ctrl_pkg.sv ====
/*
  host bus, register map and state encodings of the coprocessor.
  bus strobes cs, rd and wr are active low.
  address 9 is the start strobe on write and result byte 0 on read.
*/
package fpu_ctrl_pkg;

  typedef logic [3:0] reg_addr_t;
  typedef logic [7:0] bus_data_t;

  // only multiply and divide are implemented
  typedef enum logic [3:0] {
    op_mul = 4'd2,
    op_div = 4'd3
  } fpu_op_e;

  // ------------------------------
  // register map
  // ------------------------------
  localparam reg_addr_t reg_a0    = 4'h0;
  localparam reg_addr_t reg_a1    = 4'h1;
  localparam reg_addr_t reg_a2    = 4'h2;
  localparam reg_addr_t reg_a3    = 4'h3;
  localparam reg_addr_t reg_b0    = 4'h4;
  localparam reg_addr_t reg_b1    = 4'h5;
  localparam reg_addr_t reg_b2    = 4'h6;
  localparam reg_addr_t reg_b3    = 4'h7;
  localparam reg_addr_t reg_op    = 4'h8;
  localparam reg_addr_t reg_start = 4'h9;
  // result bytes, r0 shares the start address
  localparam reg_addr_t reg_r0    = 4'h9;
  localparam reg_addr_t reg_r1    = 4'ha;
  localparam reg_addr_t reg_r2    = 4'hb;
  localparam reg_addr_t reg_r3    = 4'hc;

  // host request, strobes active low
  typedef struct packed {
    reg_addr_t addr;
    logic      cs;
    logic      rd;
    logic      wr;
    bus_data_t wdata;
  } bus_req_t;

  // ------------------------------
  // state machines
  // ------------------------------
  typedef enum logic [1:0] {seq_idle, seq_run, seq_ack} seq_state_e;
  typedef enum logic [1:0] {mul_idle, mul_add, mul_shift} mul_state_e;
  typedef enum logic [1:0] {div_idle, div_test, div_shift} div_state_e;

endpackage

// ==== src/fpu_fmt_pkg.sv ====
/*
  binary32 word layout and field types for the coprocessor datapath.
  only normal operands are supported, so zero, subnormal, infinity and
  nan encodings have no meaning here.
*/
package fpu_fmt_pkg;

  // ------------------------------
  // format constants
  // ------------------------------
  localparam int exp_bias = 127;
  // significand width with the hidden bit
  localparam int mant_w = 24;

  // ------------------------------
  // field types
  // ------------------------------
  typedef logic [31:0] fp32_t;
  typedef logic [7:0]  exp_t;
  typedef logic [22:0] frac_t;

  // ieee bit order, sign in bit 31
  typedef struct packed {
    logic  sign;
    exp_t  exp;
    frac_t frac;
  } fp_fields_t;

  // operand pair seen by both units and the result stage
  typedef struct packed {
    fp32_t a;
    fp32_t b;
  } operands_t;

endpackage

// ==== src/fpu_restoring_div.sv ====
/*
  iterative restoring significand divider.
  hidden bits are assumed set, so operands must be normal.
  quotient is floor(ma * 2^(mant_w) / mb), mant_w+1 bits wide, top bit
  set when ma >= mb. done follows start by 1 + 2*(mant_w+1) cycles.
*/
`timescale 1ns/1ps

module fpu_restoring_div
  import fpu_fmt_pkg::*, fpu_ctrl_pkg::*;
#(
  parameter int mant_w = 24
) (
  input  logic            clk,
  input  logic            arst,
  input  logic            start,
  input  operands_t       ops,
  output logic            done,
  output logic [mant_w:0] quotient
);

  localparam int cnt_w = $clog2(mant_w + 1);

  div_state_e        state;
  logic [cnt_w-1:0]  count;
  logic              last;
  logic [mant_w-1:0] dvsr;
  // remainder stays below twice the divisor
  logic [mant_w:0]   rem;
  logic [mant_w+1:0] trial;

  // top bit set means the trial went negative
  assign trial = {1'b0, rem} - {2'b00, dvsr};
  assign last  = (count == cnt_w'(mant_w));

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      state <= div_idle;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        div_idle: begin
          count <= '0;
          if (start) state <= div_test;
        end
        div_test: state <= div_shift;
        div_shift: begin
          count <= count + 1'b1;
          state <= last ? div_idle : div_test;
          done  <= last;
        end
        default: state <= div_idle;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    case (state)
      div_idle: if (start) begin
        dvsr <= {1'b1, ops.b[mant_w-2:0]};
        rem  <= {2'b01, ops.a[mant_w-2:0]};
      end
      div_test: begin
        quotient <= {quotient[mant_w-1:0], !trial[mant_w+1]};
        // keep the difference only when it did not go negative
        if (!trial[mant_w+1]) rem <= trial[mant_w:0];
      end
      div_shift: rem <= rem << 1;
      default: ;
    endcase
  end

endmodule

// ==== src/fpu_result_pack.sv ====
/*
  normalizes the raw value of the unit that finished and registers it
  as an ieee word. the fraction is truncated.
  exponent overflow and underflow are not detected.
*/
`timescale 1ns/1ps

module fpu_result_pack
  import fpu_fmt_pkg::*;
(
  input  logic                clk,
  input  logic                arst,
  input  operands_t           ops,
  input  logic                mul_done,
  input  logic [2*mant_w-1:0] product,
  input  logic                div_done,
  input  logic [mant_w:0]     quotient,
  output fp32_t               result,
  output logic                result_valid
);

  fp_fields_t fa;
  fp_fields_t fb;
  fp_fields_t mul_f;
  fp_fields_t div_f;
  logic       sign;
  logic       mul_hi;
  logic       div_hi;
  logic [9:0] mul_exp;
  logic [9:0] div_exp;

  assign fa     = ops.a;
  assign fb     = ops.b;
  assign sign   = fa.sign ^ fb.sign;
  // product in [1,4), quotient in (1/2,2)
  assign mul_hi = product[2*mant_w-1];
  assign div_hi = quotient[mant_w];

  // ------------------------------
  // exponents, kept wide then cut
  // ------------------------------
  assign mul_exp = {2'b00, fa.exp} + {2'b00, fb.exp} - 10'(exp_bias) + {9'd0, mul_hi};
  assign div_exp = {2'b00, fa.exp} - {2'b00, fb.exp} + 10'(exp_bias - 1) + {9'd0, div_hi};

  always_comb begin
    mul_f.sign = sign;
    mul_f.exp  = mul_exp[7:0];
    mul_f.frac = mul_hi ? product[2*mant_w-2:mant_w] : product[2*mant_w-3:mant_w-1];
    div_f.sign = sign;
    div_f.exp  = div_exp[7:0];
    div_f.frac = div_hi ? quotient[mant_w-1:1] : quotient[mant_w-2:0];
  end

  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= mul_done || div_done;
      if (mul_done) begin
        result <= mul_f;
      end else if (div_done) begin
        result <= div_f;
      end
    end
  end

  a_one_done: assert property (@(posedge clk) disable iff (arst)
    !(mul_done && div_done))
    else $error("both units finished in the same cycle");

endmodule

// ==== src/fpu_sequencer.sv ====
/*
  command sequencer. one start strobe launches exactly one unit.
  busy and cmd_end are registered and held until end_ack is sampled.
  start strobes outside idle are ignored.
*/
`timescale 1ns/1ps

module fpu_sequencer
  import fpu_ctrl_pkg::*;
(
  input  logic clk,
  input  logic arst,
  input  logic start,
  input  logic is_div,
  input  logic result_valid,
  input  logic end_ack,
  output logic mul_start,
  output logic div_start,
  output logic busy,
  output logic cmd_end
);

  seq_state_e state;
  seq_state_e state_nxt;
  logic       launch;

  assign launch = (state == seq_idle) && start;

  always_comb begin
    state_nxt = state;
    case (state)
      seq_idle: if (start) state_nxt = seq_run;
      // result stage pulses once per command
      seq_run:  if (result_valid) state_nxt = seq_ack;
      seq_ack:  if (end_ack) state_nxt = seq_idle;
      default:  state_nxt = seq_idle;
    endcase
  end

  // outputs follow the next state
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      state     <= seq_idle;
      mul_start <= 1'b0;
      div_start <= 1'b0;
      busy      <= 1'b0;
      cmd_end   <= 1'b0;
    end else begin
      state     <= state_nxt;
      mul_start <= launch && !is_div;
      div_start <= launch && is_div;
      busy      <= (state_nxt != seq_idle);
      cmd_end   <= (state_nxt == seq_ack);
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  // each command launches exactly one unit, on the edge where busy rises
  a_one_unit: assert property (@(posedge clk) disable iff (arst)
    (mul_start || div_start || $rose(busy)) |-> $rose(busy) && (mul_start != div_start))
    else $error("unit launch does not match the start of a command");

  // host must see cmd_end until it acknowledges
  a_end_held: assert property (@(posedge clk) disable iff (arst)
    cmd_end && !end_ack |=> cmd_end && busy)
    else $error("cmd_end dropped before end_ack");

endmodule

// ==== src/fpu_shift_add_mul.sv ====
/*
  iterative shift and add significand multiplier.
  hidden bits are assumed set, so operands must be normal.
  done follows start by 1 + 2*mant_w cycles, product is held until the
  next start.
*/
`timescale 1ns/1ps

module fpu_shift_add_mul
  import fpu_fmt_pkg::*, fpu_ctrl_pkg::*;
#(
  parameter int mant_w = 24
) (
  input  logic                clk,
  input  logic                arst,
  input  logic                start,
  input  operands_t           ops,
  output logic                done,
  output logic [2*mant_w-1:0] product
);

  localparam int cnt_w = $clog2(mant_w);

  mul_state_e        state;
  logic [cnt_w-1:0]  count;
  logic              last;
  logic [mant_w-1:0] mcand;
  // carry on top, partial product above the multiplier bits
  logic [2*mant_w:0] acc;

  assign last    = (count == cnt_w'(mant_w - 1));
  assign product = acc[2*mant_w-1:0];

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      state <= mul_idle;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        mul_idle: begin
          count <= '0;
          if (start) state <= mul_add;
        end
        mul_add: state <= mul_shift;
        mul_shift: begin
          count <= count + 1'b1;
          state <= last ? mul_idle : mul_add;
          done  <= last;
        end
        default: state <= mul_idle;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    case (state)
      mul_idle: if (start) begin
        mcand <= {1'b1, ops.a[mant_w-2:0]};
        acc   <= {{(mant_w+1){1'b0}}, 1'b1, ops.b[mant_w-2:0]};
      end
      mul_add: if (acc[0]) acc[2*mant_w:mant_w] <= acc[2*mant_w:mant_w] + {1'b0, mcand};
      mul_shift: acc <= acc >> 1;
      default: ;
    endcase
  end

  // done only ever ends a run launched 1 + 2*mant_w cycles earlier
  a_done_latency: assert property (@(posedge clk) disable iff (arst)
    done |-> $past(start, 2*mant_w + 1))
    else $error("multiplier done without a start 1 + 2*mant_w cycles earlier");

endmodule

// ==== src/fpu_top.sv ====
/*
  single precision multiply and divide coprocessor on an 8-bit host bus.
  operands must be normal and results must stay in the normal range.
  results are truncated and written back into operand a for chaining.
  the host waits for cmd_end and answers with end_ack.
*/
`timescale 1ns/1ps

module fpu_top
  import fpu_fmt_pkg::*, fpu_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      arst,
  input  bus_req_t  bus,
  output bus_data_t rdata,
  input  logic      end_ack,
  output logic      busy,
  output logic      cmd_end
);

  operands_t           ops;
  fp32_t               result;
  logic                result_valid;
  logic                start;
  logic                is_div;
  logic                mul_start;
  logic                div_start;
  logic                mul_done;
  logic                div_done;
  logic [2*mant_w-1:0] product;
  logic [mant_w:0]     quotient;

  fpu_bus_regs u_bus_regs (
    .clk          (clk),
    .arst         (arst),
    .bus          (bus),
    .rdata        (rdata),
    .ops          (ops),
    .result       (result),
    .result_valid (result_valid),
    .start        (start),
    .is_div       (is_div)
  );

  fpu_sequencer u_sequencer (
    .clk          (clk),
    .arst         (arst),
    .start        (start),
    .is_div       (is_div),
    .result_valid (result_valid),
    .end_ack      (end_ack),
    .mul_start    (mul_start),
    .div_start    (div_start),
    .busy         (busy),
    .cmd_end      (cmd_end)
  );

  // both units see the same operands, only one is launched
  fpu_shift_add_mul #(.mant_w(mant_w)) u_mul (
    .clk     (clk),
    .arst    (arst),
    .start   (mul_start),
    .ops     (ops),
    .done    (mul_done),
    .product (product)
  );

  fpu_restoring_div #(.mant_w(mant_w)) u_div (
    .clk      (clk),
    .arst     (arst),
    .start    (div_start),
    .ops      (ops),
    .done     (div_done),
    .quotient (quotient)
  );

  fpu_result_pack u_result_pack (
    .clk          (clk),
    .arst         (arst),
    .ops          (ops),
    .mul_done     (mul_done),
    .product      (product),
    .div_done     (div_done),
    .quotient     (quotient),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

// ==== test/fpu_checker.sv ====
/*
  bus monitor and reference model for the coprocessor testbench.
  samples the bus and status outputs on the rising edge.
  assumes the host waits for cmd_end before the next command.
*/
`timescale 1ns/1ps

module fpu_checker
  import fpu_fmt_pkg::*, fpu_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      arst,
  input  bus_req_t  bus,
  input  bus_data_t rdata,
  input  logic      busy,
  input  logic      cmd_end,
  input  logic      end_ack,
  input  int        test_id,
  input  logic      test_end,
  output int        errors,
  output int        checks
);

  fp32_t      m_a;
  fp32_t      m_b;
  fp32_t      m_r;
  fp32_t      pending;
  logic [3:0] m_op;
  logic       have_pending;
  logic       start_seen;
  logic       cmd_open;
  int         test_errors;
  int         test_checks;

  // ------------------------------
  // arithmetic model
  // ------------------------------
  function automatic fp32_t mul_model(input fp32_t a, input fp32_t b);
    logic [47:0] p;
    logic [9:0]  e;
    logic [22:0] f;
    p = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
    e = {2'b00, a[30:23]} + {2'b00, b[30:23]} - 10'd127;
    if (p[47]) begin
      f = p[46:24];
      e = e + 10'd1;
    end else begin
      f = p[45:23];
    end
    return {a[31] ^ b[31], e[7:0], f};
  endfunction

  function automatic fp32_t div_model(input fp32_t a, input fp32_t b);
    logic [47:0] q;
    logic [9:0]  e;
    logic [22:0] f;
    q = {1'b1, a[22:0], 24'd0} / {24'd0, 1'b1, b[22:0]};
    e = {2'b00, a[30:23]} - {2'b00, b[30:23]} + 10'd126;
    if (q[24]) begin
      f = q[23:1];
      e = e + 10'd1;
    end else begin
      f = q[22:0];
    end
    return {a[31] ^ b[31], e[7:0], f};
  endfunction

  function automatic bus_data_t model_byte(input reg_addr_t addr);
    case (addr)
      4'h0, 4'h1, 4'h2, 4'h3: return m_a[8*addr[1:0] +: 8];
      4'h4, 4'h5, 4'h6, 4'h7: return m_b[8*addr[1:0] +: 8];
      reg_op:                 return {4'h0, m_op};
      reg_r0:                 return m_r[7:0];
      reg_r1:                 return m_r[15:8];
      reg_r2:                 return m_r[23:16];
      reg_r3:                 return m_r[31:24];
      default:                return 8'h00;
    endcase
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset state";
      2:       return "register readback";
      3:       return "multiply";
      4:       return "divide";
      5:       return "chaining";
      6:       return "unsupported op";
      default: return "unknown";
    endcase
  endfunction

  task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    errors      = errors + 1;
    test_errors = test_errors + 1;
    $display("Error: %s expected %h got %h", name, exp, act);
  endtask

  // ------------------------------
  // monitor
  // ------------------------------
  always @(posedge clk) begin
    if (arst) begin
      m_a          = 32'h3f80_0000;
      m_b          = 32'h3f80_0000;
      m_r          = '0;
      m_op         = op_mul;
      have_pending = 1'b0;
      start_seen   = 1'b0;
      cmd_open     = 1'b0;
      errors       = 0;
      checks       = 0;
      test_errors  = 0;
      test_checks  = 0;
    end else begin
      // busy rises one cycle after the start write
      if (cmd_open) begin
        if (!busy) fail_value("busy", 32'h1, {31'd0, busy});
      end else begin
        if (busy) fail_value("busy", 32'h0, {31'd0, busy});
        if (cmd_end) fail_value("cmd_end", 32'h0, {31'd0, cmd_end});
      end
      if (cmd_end && have_pending) begin
        m_r          = pending;
        m_a          = pending;
        have_pending = 1'b0;
      end

      if (!bus.cs && !bus.rd) begin
        checks      = checks + 1;
        test_checks = test_checks + 1;
        if (bus.addr >= reg_r0 && bus.addr <= reg_r3 && cmd_open && !cmd_end) begin
          errors      = errors + 1;
          test_errors = test_errors + 1;
          $display("result byte read while the command was still running");
        end
        if (rdata !== model_byte(bus.addr)) begin
          fail_value($sformatf("rdata at addr %h", bus.addr),
                     {24'd0, model_byte(bus.addr)}, {24'd0, rdata});
        end
      end

      if (cmd_open && cmd_end && end_ack) cmd_open = 1'b0;
      if (start_seen) cmd_open = 1'b1;
      start_seen = 1'b0;

      if (!bus.cs && !bus.wr) begin
        case (bus.addr)
          4'h0, 4'h1, 4'h2, 4'h3: m_a[8*bus.addr[1:0] +: 8] = bus.wdata;
          4'h4, 4'h5, 4'h6, 4'h7: m_b[8*bus.addr[1:0] +: 8] = bus.wdata;
          reg_op: m_op = bus.wdata[3:0];
          reg_start: begin
            if (!cmd_open && (m_op == op_mul || m_op == op_div)) begin
              pending      = (m_op == op_mul) ? mul_model(m_a, m_b) : div_model(m_a, m_b);
              have_pending = 1'b1;
              start_seen   = 1'b1;
            end
          end
          default: ;
        endcase
      end

      if (test_end) begin
        $display("test %0d %s: %0d checks, %0d errors",
                 test_id, test_name(test_id), test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
      end
    end
  end

endmodule

// ==== test/tb_fpu.sv ====
/*
  testbench for the coprocessor. bus inputs change on the falling edge.
  operands are random normal numbers with exponents 96 to 158, so all
  results stay in the normal range. fpu_checker does all comparing.
*/
`timescale 1ns/1ps

module tb_fpu
  import fpu_fmt_pkg::*, fpu_ctrl_pkg::*;
();

  localparam int n_regs      = 50;
  localparam int n_rand      = 100;
  localparam int n_chain     = 20;
  localparam int n_ops       = 2 * n_rand + 2 * n_chain;
  // 18 accesses per operation plus the reset and register tests
  localparam int n_access    = 13 + 2 * n_regs + 18 * n_ops + 8;
  localparam int cycle_limit = n_ops * 120 + n_access * 20 + 500;

  logic        clk;
  logic        arst;
  logic        end_ack;
  logic        busy;
  logic        cmd_end;
  logic        test_end;
  bus_req_t    bus;
  bus_data_t   rdata;
  int          test_id;
  int          errors;
  int          checks;
  int          cycles = 0;
  logic [31:0] rng;

  fpu_top u_fpu_top (
    .clk     (clk),
    .arst    (arst),
    .bus     (bus),
    .rdata   (rdata),
    .end_ack (end_ack),
    .busy    (busy),
    .cmd_end (cmd_end)
  );

  fpu_checker u_checker (
    .clk      (clk),
    .arst     (arst),
    .bus      (bus),
    .rdata    (rdata),
    .busy     (busy),
    .cmd_end  (cmd_end),
    .end_ack  (end_ack),
    .test_id  (test_id),
    .test_end (test_end),
    .errors   (errors),
    .checks   (checks)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run stopped after %0d cycles, a command never completed", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  // ------------------------------
  // random numbers
  // ------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic fp32_t rand_operand();
    logic [31:0] r1;
    logic [31:0] r2;
    r1 = next_rand();
    r2 = next_rand();
    return {r1[31], 8'(32'd96 + (r2 % 32'd63)), r1[22:0]};
  endfunction

  // ------------------------------
  // bus tasks
  // ------------------------------
  task automatic bus_write(input reg_addr_t addr, input bus_data_t data);
    @(negedge clk);
    bus.addr  = addr;
    bus.wdata = data;
    bus.cs    = 1'b0;
    bus.wr    = 1'b0;
    @(negedge clk);
    bus.cs = 1'b1;
    bus.wr = 1'b1;
  endtask

  task automatic bus_read(input reg_addr_t addr);
    @(negedge clk);
    bus.addr = addr;
    bus.cs   = 1'b0;
    bus.rd   = 1'b0;
    @(negedge clk);
    bus.cs = 1'b1;
    bus.rd = 1'b1;
  endtask

  task automatic write_word(input reg_addr_t base, input fp32_t value);
    for (int i = 0; i < 4; i++) begin
      bus_write(base + reg_addr_t'(i), value[8*i +: 8]);
    end
  endtask

  task automatic read_word(input reg_addr_t base);
    for (int i = 0; i < 4; i++) begin
      bus_read(base + reg_addr_t'(i));
    end
  endtask

  // one command, then result and operand a readback and the ack
  task automatic run_op(input logic [3:0] op, input fp32_t a, input fp32_t b,
                        input logic write_a);
    bus_write(reg_op, {4'h0, op});
    if (write_a) write_word(reg_a0, a);
    write_word(reg_b0, b);
    bus_write(reg_start, 8'h00);
    while (!cmd_end) @(negedge clk);
    read_word(reg_r0);
    read_word(reg_a0);
    @(negedge clk);
    end_ack = 1'b1;
    @(negedge clk);
    end_ack = 1'b0;
  endtask

  task automatic end_test();
    @(negedge clk);
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
    test_id  = test_id + 1;
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    logic [31:0] r;
    fp32_t       a;
    fp32_t       b;
    bus.addr  = '0;
    bus.wdata = '0;
    bus.cs    = 1'b1;
    bus.rd    = 1'b1;
    bus.wr    = 1'b1;
    end_ack   = 1'b0;
    test_end  = 1'b0;
    test_id   = 1;
    rng       = 32'ha135;
    arst      = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst = 1'b0;

    for (int i = 0; i <= 12; i++) bus_read(reg_addr_t'(i));
    end_test();

    repeat (n_regs) begin
      r = next_rand();
      bus_write(4'(r % 32'd9), r[15:8]);
      bus_read(4'(r % 32'd9));
    end
    end_test();

    repeat (n_rand) begin
      a = rand_operand();
      b = rand_operand();
      run_op(op_mul, a, b, 1'b1);
    end
    end_test();

    repeat (n_rand) begin
      a = rand_operand();
      b = rand_operand();
      run_op(op_div, a, b, 1'b1);
    end
    end_test();

    // second command reuses the result left in operand a
    for (int i = 0; i < n_chain; i++) begin
      a = rand_operand();
      b = rand_operand();
      run_op((i % 2 == 0) ? op_mul : op_div, a, b, 1'b1);
      b = rand_operand();
      run_op((i % 2 == 0) ? op_div : op_mul, a, b, 1'b0);
    end
    end_test();

    bus_write(reg_op, 8'h00);
    bus_write(reg_start, 8'h00);
    repeat (60) @(negedge clk);
    read_word(reg_r0);
    bus_read(reg_op);
    end_test();

    repeat (4) @(negedge clk);
    $display("done: %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
